// ==== nco.sv ====
`timescale 1ns/1ns

// One phase accumulator per slot, updated when its slot comes round.
// The result leaves through a single register stage together with the
// slot tags and the modulation value of the same slot.
module nco
    import osc_pkg::*;
(
    input  logic                     sCLK_XVXOSC,
    input  logic                     reset_data_N,
    input  logic [V_WIDTH-1:0]       slot_voice,
    input  logic [O_WIDTH-1:0]       slot_osc,
    input  logic [PHASE_W-1:0]       osc_pitch_val,
    input  logic signed [MOD_W-1:0]  modulation,
    input  logic [VOICES-1:0]        osc_accum_zero,
    output logic [PHASE_W-1:0]       phase_acc,
    output logic [V_WIDTH-1:0]       phase_voice,
    output logic [O_WIDTH-1:0]       phase_osc,
    output logic signed [MOD_W-1:0]  phase_mod,
    output logic                     phase_valid
);

    logic [PHASE_W-1:0] acc_mem [SLOTS];
    logic [S_WIDTH-1:0] slot_idx;
    logic [PHASE_W-1:0] acc_base;
    logic [PHASE_W-1:0] acc_next;

    assign slot_idx = {slot_voice, slot_osc};

    // **************************************************
    // Read-modify-write of the current slot
    // **************************************************
    assign acc_base = osc_accum_zero[slot_voice] ? '0 : acc_mem[slot_idx];  // Voice restart
    assign acc_next = acc_base + osc_pitch_val;  // Modulo 2^24

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            for (int s = 0; s < SLOTS; s++) begin
                acc_mem[s] <= '0;
            end
        end else begin
            acc_mem[slot_idx] <= acc_next;
        end
    end

    // **************************************************
    // Output stage
    // **************************************************
    always_ff @(posedge sCLK_XVXOSC) begin
        phase_acc   <= acc_next;
        phase_voice <= slot_voice;
        phase_osc   <= slot_osc;
        phase_mod   <= modulation;                // Follows its slot
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= 1'b1;                  // One slot every cycle
        end
    end

endmodule

// ==== osc.sv ====
`timescale 1ns/1ns

// Oscillator block. Holds the per-oscillator phase offsets behind the
// byte register bus and builds the sine table address from the NCO
// stage, the modulation and the offset.
module osc
    import osc_pkg::*;
(
    input  logic                       sCLK_XVXOSC,
    input  logic                       reset_data_N,
    input  logic [ADR_W-1:0]           adr,
    input  logic [DATA_W-1:0]          wdata,
    input  logic                       write,
    input  logic                       read,
    input  logic                       osc_sel,
    input  logic [V_WIDTH-1:0]         slot_voice,
    input  logic [O_WIDTH-1:0]         slot_osc,
    input  logic [PHASE_W-1:0]         osc_pitch_val,
    input  logic signed [MOD_W-1:0]    modulation,
    input  logic [VOICES-1:0]          osc_accum_zero,
    output logic [DATA_W-1:0]          rdata,
    output logic signed [SAMPLE_W-1:0] sine_out,
    output logic [V_WIDTH-1:0]         sine_voice,
    output logic [O_WIDTH-1:0]         sine_osc,
    output logic                       sine_valid
);

    logic signed [DATA_W-1:0] o_offs [V_OSC];
    logic [V_OSC-1:0]         offs_hit;
    logic [DATA_W-1:0]        rd_mux;

    logic [PHASE_W-1:0]       phase_acc;
    logic [V_WIDTH-1:0]       phase_voice;
    logic [O_WIDTH-1:0]       phase_osc;
    logic signed [MOD_W-1:0]  phase_mod;
    logic                     phase_valid;

    logic [ADDR_W-1:0]        offs_term;
    logic [ADDR_W-1:0]        tab_addr;

    // **************************************************
    // Offset registers
    // **************************************************
    always_comb begin
        for (int k = 0; k < V_OSC; k++) begin
            offs_hit[k] = (adr == offs_addr(k));
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            for (int k = 0; k < V_OSC; k++) begin
                o_offs[k] <= '0;
            end
        end else if (osc_sel && write) begin
            for (int k = 0; k < V_OSC; k++) begin
                if (offs_hit[k]) o_offs[k] <= wdata;
            end
        end
    end

    // Readback, zero for unmapped addresses
    always_comb begin
        rd_mux = '0;
        for (int k = 0; k < V_OSC; k++) begin
            if (offs_hit[k]) rd_mux = o_offs[k];
        end
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            rdata <= '0;
        end else if (osc_sel && read) begin
            rdata <= rd_mux;                      // Held until next read
        end
    end

    // **************************************************
    // Phase accumulators
    // **************************************************
    nco u_nco (
        .sCLK_XVXOSC    (sCLK_XVXOSC),
        .reset_data_N   (reset_data_N),
        .slot_voice     (slot_voice),
        .slot_osc       (slot_osc),
        .osc_pitch_val  (osc_pitch_val),
        .modulation     (modulation),
        .osc_accum_zero (osc_accum_zero),
        .phase_acc      (phase_acc),
        .phase_voice    (phase_voice),
        .phase_osc      (phase_osc),
        .phase_mod      (phase_mod),
        .phase_valid    (phase_valid)
    );

    // Offset sign-extended, then times 8
    assign offs_term = ADDR_W'(o_offs[phase_osc]) << 3;
    assign tab_addr  = phase_acc[PHASE_W-1 -: ADDR_W] + ADDR_W'(phase_mod) + offs_term;

    sine_lookup u_sine (
        .sCLK_XVXOSC  (sCLK_XVXOSC),
        .reset_data_N (reset_data_N),
        .addr         (tab_addr),
        .addr_voice   (phase_voice),
        .addr_osc     (phase_osc),
        .addr_valid   (phase_valid),
        .sine_out     (sine_out),
        .sine_voice   (sine_voice),
        .sine_osc     (sine_osc),
        .sine_valid   (sine_valid)
    );

endmodule

// ==== osc_chk.sv ====
`timescale 1ns/1ns

// Assertions on the oscillator section ports, bound to osc_top
module osc_chk
    import osc_pkg::*;
(
    input logic               sCLK_XVXOSC,
    input logic               reset_data_N,
    input logic [V_WIDTH-1:0] slot_voice,
    input logic [O_WIDTH-1:0] slot_osc,
    input logic [V_WIDTH-1:0] sine_voice,
    input logic [O_WIDTH-1:0] sine_osc,
    input logic               sine_valid
);

    logic [S_WIDTH-1:0] slot;
    logic [S_WIDTH-1:0] tag;

    assign slot = {slot_voice, slot_osc};
    assign tag  = {sine_voice, sine_osc};

    // **************************************************
    // Port rules
    // **************************************************
    a_valid_in_reset: assert property (@(posedge sCLK_XVXOSC)
        !reset_data_N ##1 !reset_data_N |-> !sine_valid)  // First edge clears it
        else $error("sine_valid high while reset is held");

    a_slot_step: assert property (@(posedge sCLK_XVXOSC)
        $past(reset_data_N) |-> slot == S_WIDTH'($past(slot) + 1'b1))
        else $error("slot did not advance by one");

    a_sample_tag: assert property (@(posedge sCLK_XVXOSC)
        sine_valid |-> tag == $past(slot, 2))            // Two cycle chain
        else $error("sample tag does not match slot of two cycles before");

endmodule

bind osc_top osc_chk u_chk (.*);

// ==== osc_pkg.sv ====
package osc_pkg;

    // **************************************************
    // Slot geometry
    // **************************************************
    localparam int VOICES   = 8;
    localparam int V_OSC    = 4;                  // Oscillators per voice
    localparam int V_WIDTH  = 3;
    localparam int O_WIDTH  = 2;
    localparam int S_WIDTH  = V_WIDTH + O_WIDTH;  // Slot index
    localparam int SLOTS    = VOICES * V_OSC;

    // **************************************************
    // Datapath widths
    // **************************************************
    localparam int PHASE_W  = 24;                 // Accumulator and pitch
    localparam int ADDR_W   = 11;                 // Sine table address
    localparam int MOD_W    = 11;
    localparam int SAMPLE_W = 17;
    localparam int TAB_SIZE = 1 << ADDR_W;

    // Sine table amplitude
    localparam int  SINE_AMP = 65535;
    localparam real PI       = 3.14159265358979323846;

    // **************************************************
    // Register bus
    // **************************************************
    localparam int ADR_W       = 7;
    localparam int DATA_W      = 8;
    localparam int OFFS_BASE   = 6;
    localparam int OFFS_STRIDE = 16;

    // Address of offset register for oscillator k
    function automatic logic [ADR_W-1:0] offs_addr(input int k);
        return ADR_W'(OFFS_BASE + OFFS_STRIDE * k);
    endfunction

endpackage

// ==== osc_top.sv ====
`timescale 1ns/1ns

// Oscillator section top. The sequencer picks the slot, and the slot is
// also shown outside so pitch and modulation can be supplied for it.
module osc_top
    import osc_pkg::*;
(
    input  logic                       sCLK_XVXOSC,
    input  logic                       reset_data_N,
    input  logic [ADR_W-1:0]           adr,
    input  logic [DATA_W-1:0]          wdata,
    input  logic                       write,
    input  logic                       read,
    input  logic                       osc_sel,
    input  logic [PHASE_W-1:0]         osc_pitch_val,
    input  logic signed [MOD_W-1:0]    modulation,
    input  logic [VOICES-1:0]          osc_accum_zero,
    output logic [DATA_W-1:0]          rdata,
    output logic signed [SAMPLE_W-1:0] sine_out,
    output logic [V_WIDTH-1:0]         sine_voice,
    output logic [O_WIDTH-1:0]         sine_osc,
    output logic                       sine_valid,
    output logic [V_WIDTH-1:0]         slot_voice,
    output logic [O_WIDTH-1:0]         slot_osc
);

    slot_sequencer u_seq (
        .sCLK_XVXOSC  (sCLK_XVXOSC),
        .reset_data_N (reset_data_N),
        .slot_voice   (slot_voice),
        .slot_osc     (slot_osc)
    );

    osc u_osc (
        .sCLK_XVXOSC    (sCLK_XVXOSC),
        .reset_data_N   (reset_data_N),
        .adr            (adr),
        .wdata          (wdata),
        .write          (write),
        .read           (read),
        .osc_sel        (osc_sel),
        .slot_voice     (slot_voice),     // Same slot as shown outside
        .slot_osc       (slot_osc),
        .osc_pitch_val  (osc_pitch_val),
        .modulation     (modulation),
        .osc_accum_zero (osc_accum_zero),
        .rdata          (rdata),
        .sine_out       (sine_out),
        .sine_voice     (sine_voice),
        .sine_osc       (sine_osc),
        .sine_valid     (sine_valid)
    );

endmodule

// ==== sine_lookup.sv ====
`timescale 1ns/1ns

// Full-wave sine ROM with a registered output.
// Table contents are worked out at elaboration from the sine rule.
module sine_lookup
    import osc_pkg::*;
(
    input  logic                       sCLK_XVXOSC,
    input  logic                       reset_data_N,
    input  logic [ADDR_W-1:0]          addr,
    input  logic [V_WIDTH-1:0]         addr_voice,
    input  logic [O_WIDTH-1:0]         addr_osc,
    input  logic                       addr_valid,
    output logic signed [SAMPLE_W-1:0] sine_out,
    output logic [V_WIDTH-1:0]         sine_voice,
    output logic [O_WIDTH-1:0]         sine_osc,
    output logic                       sine_valid
);

    typedef logic signed [SAMPLE_W-1:0] sine_tab_t [TAB_SIZE];

    // **************************************************
    // Table generation
    // **************************************************
    function automatic sine_tab_t build_sine();
        sine_tab_t tab;
        real       x;
        real       r;
        for (int a = 0; a < TAB_SIZE; a++) begin
            x = SINE_AMP * $sin(2.0 * PI * a / TAB_SIZE);
            // Round half away from zero
            r = (x < 0.0) ? x - 0.5 : x + 0.5;
            tab[a] = SAMPLE_W'($rtoi(r));
        end
        return tab;
    endfunction

    localparam sine_tab_t SINE_TAB = build_sine();

    // **************************************************
    // Registered lookup
    // **************************************************
    always_ff @(posedge sCLK_XVXOSC) begin
        sine_out   <= SINE_TAB[addr];
        sine_voice <= addr_voice;                 // Tags ride with the sample
        sine_osc   <= addr_osc;
    end

    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            sine_valid <= 1'b0;
        end else begin
            sine_valid <= addr_valid;
        end
    end

endmodule

// ==== slot_sequencer.sv ====
`timescale 1ns/1ns

// Walks the 32 voice/oscillator slots, one per clock.
// The oscillator field sits in the low bits so it runs fastest.
module slot_sequencer
    import osc_pkg::*;
(
    input  logic               sCLK_XVXOSC,
    input  logic               reset_data_N,
    output logic [V_WIDTH-1:0] slot_voice,
    output logic [O_WIDTH-1:0] slot_osc
);

    logic [S_WIDTH-1:0] slot_cnt;

    // **************************************************
    // Slot counter
    // **************************************************
    always_ff @(posedge sCLK_XVXOSC) begin
        if (!reset_data_N) begin
            slot_cnt <= '0;                       // Slot 0 shown first
        end else begin
            slot_cnt <= slot_cnt + 1'b1;          // Wraps at end of frame
        end
    end

    // Split into voice and oscillator fields
    assign slot_voice = slot_cnt[S_WIDTH-1:O_WIDTH];
    assign slot_osc   = slot_cnt[O_WIDTH-1:0];

endmodule

// ==== tb_osc.sv ====
`timescale 1ns/1ns

module tb_osc
    import osc_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int FRAME        = SLOTS;
    localparam int DRAIN        = 2;
    // Cycle budget of each test, in order
    localparam int RUN_CYCLES   = (RESET_CYCLES + FRAME + V_OSC) + 20
                                + (4 * FRAME + DRAIN) + (2 * FRAME + 8 + DRAIN)
                                + (2 * FRAME + DRAIN) + (2 * FRAME + DRAIN);
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 100;

    logic                       sCLK_XVXOSC;
    logic                       reset_data_N;
    logic [ADR_W-1:0]           adr;
    logic [DATA_W-1:0]          wdata;
    logic                       write;
    logic                       read;
    logic                       osc_sel;
    logic [PHASE_W-1:0]         osc_pitch_val;
    logic signed [MOD_W-1:0]    modulation;
    logic [VOICES-1:0]          osc_accum_zero;
    logic [DATA_W-1:0]          rdata;
    logic signed [SAMPLE_W-1:0] sine_out;
    logic [V_WIDTH-1:0]         sine_voice;
    logic [O_WIDTH-1:0]         sine_osc;
    logic                       sine_valid;
    logic [V_WIDTH-1:0]         slot_voice;
    logic [O_WIDTH-1:0]         slot_osc;

    // Reference model state
    logic [PHASE_W-1:0] shadow_phase [SLOTS];
    logic [PHASE_W-1:0] pitch_tab [SLOTS];
    logic [DATA_W-1:0]  offs_copy [V_OSC];
    bit                 pipe_vld [2];          // Expected samples in flight
    int                 pipe_tag [2];
    int                 pipe_smp [2];

    integer seed = 32'he28e_18d6;
    int     errors;
    int     checks;
    int     tests;

    osc_top u_dut (.*);

    initial begin
        sCLK_XVXOSC = 1'b0;
        forever #(CLK_PERIOD / 2) sCLK_XVXOSC = ~sCLK_XVXOSC;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // **************************************************
    // Helpers
    // **************************************************
    task automatic compare(input integer got, input integer exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int sine_ref(input int a);
        real x;
        x = SINE_AMP * $sin(2.0 * 3.14159265358979323846 * a / 2048);
        return (x < 0.0) ? $rtoi(x - 0.5) : $rtoi(x + 0.5);
    endfunction

    // Called at a falling edge, returns at the next one
    task automatic clock_cycle(input int mod, input logic [VOICES-1:0] zero, input bit track);
        int                 s;
        int                 hi;
        int                 off;
        logic [PHASE_W-1:0] ph;
        if (pipe_vld[1]) begin
            compare(sine_valid, 1, "sine_valid");
            compare({sine_voice, sine_osc}, pipe_tag[1], "sample tag");
            compare(sine_out, pipe_smp[1], "sine_out");
        end
        s = {slot_voice, slot_osc};
        osc_accum_zero = zero;
        modulation     = MOD_W'(mod);
        osc_pitch_val  = track ? pitch_tab[s] : '0;  // Zero pitch keeps phases
        pipe_vld[1] = pipe_vld[0];
        pipe_tag[1] = pipe_tag[0];
        pipe_smp[1] = pipe_smp[0];
        pipe_vld[0] = track;
        if (track) begin
            ph = (zero[slot_voice] ? '0 : shadow_phase[s]) + pitch_tab[s];
            shadow_phase[s] = ph;
            hi  = ph[PHASE_W-1 -: ADDR_W];
            off = $signed(offs_copy[slot_osc]);
            pipe_tag[0] = s;
            pipe_smp[0] = sine_ref((hi + mod + 8 * off) & 2047);
        end
        @(negedge sCLK_XVXOSC);
    endtask

    task automatic drain();
        repeat (DRAIN) clock_cycle(0, '0, 1'b0);
    endtask

    task automatic apply_reset();
        reset_data_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge sCLK_XVXOSC);
        @(negedge sCLK_XVXOSC);
        reset_data_N = 1'b1;
        for (int s = 0; s < SLOTS; s++) begin
            shadow_phase[s] = '0;
        end
        for (int k = 0; k < V_OSC; k++) begin
            offs_copy[k] = '0;
        end
        pipe_vld[0] = 1'b0;
        pipe_vld[1] = 1'b0;
    endtask

    task automatic reg_write(input int addr, input logic [DATA_W-1:0] data);
        adr     = ADR_W'(addr);
        wdata   = data;
        write   = 1'b1;
        osc_sel = 1'b1;
        clock_cycle(0, '0, 1'b0);
        write   = 1'b0;
        osc_sel = 1'b0;
        for (int k = 0; k < V_OSC; k++) begin
            if (addr == 6 + 16 * k) offs_copy[k] = data;
        end
    endtask

    task automatic reg_read(input int addr, input int exp);
        adr     = ADR_W'(addr);
        read    = 1'b1;
        osc_sel = 1'b1;
        clock_cycle(0, '0, 1'b0);
        read    = 1'b0;
        osc_sel = 1'b0;
        compare(rdata, exp, $sformatf("rdata at adr %0d", addr));
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("Test %0d %s: passed", tests, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests, name, errors - err_before);
        end
    endtask

    // **************************************************
    // Tests
    // **************************************************
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        apply_reset();
        compare(sine_valid, 0, "sine_valid at release");
        compare({slot_voice, slot_osc}, 0, "slot at release");
        clock_cycle(0, '0, 1'b1);              // Slot 0 gets one pitch step
        compare(sine_valid, 0, "sine_valid one cycle after release");
        compare({slot_voice, slot_osc}, 1, "slot one cycle after release");
        repeat (FRAME - 1) clock_cycle(0, '0, 1'b1);
        for (int k = 0; k < V_OSC; k++) begin
            reg_read(6 + 16 * k, 0);
        end
        finish_test("reset state", e0);
    endtask

    task automatic test_offset_regs();
        int e0;
        e0 = errors;
        reg_write(6, 8'h5a);
        reg_write(22, 8'ha5);
        reg_write(38, 8'h01);
        reg_write(54, 8'hff);
        reg_write(7, 8'h33);                   // Unmapped addresses
        reg_write(70, 8'h44);
        reg_write(0, 8'h55);
        reg_write(127, 8'h66);
        reg_read(6, offs_copy[0]);             // Nonzero before each unmapped read
        reg_read(7, 0);
        reg_read(22, offs_copy[1]);
        reg_read(70, 0);
        reg_read(54, offs_copy[3]);
        reg_read(127, 0);
        reg_read(38, offs_copy[2]);
        for (int k = 0; k < V_OSC; k++) begin
            reg_write(6 + 16 * k, 8'h00);
        end
        finish_test("offset registers", e0);
    endtask

    task automatic test_phase_stream();
        int e0;
        e0 = errors;
        repeat (4 * FRAME) clock_cycle(0, '0, 1'b1);
        drain();
        finish_test("phase stream", e0);
    endtask

    task automatic test_phase_offsets();
        int e0;
        e0 = errors;
        reg_write(6, 8'h80);                   // -128, shift of -1024
        reg_write(22, 8'h10);
        reg_write(38, 8'hf0);
        reg_write(54, 8'h7f);
        repeat (2 * FRAME) clock_cycle(0, '0, 1'b1);
        drain();
        for (int k = 0; k < V_OSC; k++) begin
            reg_write(6 + 16 * k, 8'h00);
        end
        finish_test("phase offsets", e0);
    endtask

    task automatic test_modulation();
        int e0;
        int m;
        e0 = errors;
        for (int i = 0; i < 2 * FRAME; i++) begin
            if (i == 0) m = -1024;
            else if (i == 1) m = 1023;
            else m = $random(seed) % 1024;
            clock_cycle(m, '0, 1'b1);
        end
        drain();
        finish_test("modulation", e0);
    endtask

    task automatic test_voice_zero();
        int e0;
        e0 = errors;
        repeat (FRAME) clock_cycle(0, 8'h08, 1'b1);  // Voice 3 restarts
        repeat (FRAME) clock_cycle(0, '0, 1'b1);
        drain();
        finish_test("voice zero", e0);
    endtask

    initial begin
        reset_data_N   = 1'b0;
        adr            = '0;
        wdata          = '0;
        write          = 1'b0;
        read           = 1'b0;
        osc_sel        = 1'b0;
        osc_pitch_val  = '0;
        modulation     = '0;
        osc_accum_zero = '0;
        errors = 0;
        checks = 0;
        tests  = 0;
        for (int s = 0; s < SLOTS; s++) begin
            pitch_tab[s] = $random(seed);
        end
        test_reset_state();
        test_offset_regs();
        test_phase_stream();
        test_phase_offsets();
        test_modulation();
        test_voice_zero();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
osc_pkg.sv
slot_sequencer.sv
nco.sv
sine_lookup.sv
osc.sv
osc_top.sv
osc_chk.sv
tb_osc.sv
